// File: sim.f
source/feature_pkg.sv
source/row_mem.sv
source/line_buffer.sv
source/gauss_blur.sv
source/keypoint_detect.sv
source/core_sequencer.sv
source/feature_core.sv
sim/feature_core_props.sv
sim/feature_core_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module feature_core_tb -f sim.f -o Vfeature_core_tb

run: compile
	./obj_dir/Vfeature_core_tb

clean:
	rm -rf obj_dir

// File: sim/feature_core_tb.sv
`default_nettype none

module feature_core_tb
    import feature_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      start;
    pixel_t    threshold;
    logic      img_we;
    row_addr_t img_addr;
    row_t      img_din;
    row_addr_t blur_addr;
    row_t      blur_dout;
    kp_addr_t  kp_addr;
    kp_t       kp_dout;
    kp_count_t kp_count;
    logic      busy;
    logic      done;

    int   seed;
    int   done_seen;
    row_t img_rows  [img_h];  // host copy of the image
    row_t blur_rows [img_h];  // expected blur
    kp_t  kp_ref    [$];

    feature_core DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .threshold (threshold),
        .img_we    (img_we),
        .img_addr  (img_addr),
        .img_din   (img_din),
        .blur_addr (blur_addr),
        .blur_dout (blur_dout),
        .kp_addr   (kp_addr),
        .kp_dout   (kp_dout),
        .kp_count  (kp_count),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            done_seen <= 0;
        end else if (done === 1'b1) begin
            done_seen <= done_seen + 1;
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_row(input string name, input row_t exp, input row_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_kp(input string name, input kp_t exp, input kp_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input kp_count_t exp, input kp_count_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    function automatic int tap_weight(input int d);
        return (d == 0) ? 2 : 1;
    endfunction

    function automatic pixel_t pixel_at(input int r, input int c);
        if (r < 0 || r >= img_h || c < 0 || c >= img_w) begin
            return '0;  // zero outside the image
        end
        return img_rows[r][c*pix_w +: pix_w];
    endfunction

    // 3x3 binomial blur, then keypoints in raster order
    function automatic void build_model(input pixel_t thr);
        int  sum;
        int  diff;
        kp_t k;
        kp_ref.delete();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        sum += tap_weight(dr) * tap_weight(dc) * int'(pixel_at(r + dr, c + dc));
                    end
                end
                blur_rows[r][c*pix_w +: pix_w] = pixel_t'(sum >> gauss_shift);
                diff = int'(pixel_at(r, c)) - int'(blur_rows[r][c*pix_w +: pix_w]);
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > int'(thr)) begin
                    k.row = row_addr_t'(r);
                    k.col = col_t'(c);
                    kp_ref.push_back(k);
                end
            end
        end
    endfunction

    task automatic load_image();
        for (int r = 0; r < img_h; r++) begin
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= row_addr_t'(r);
            img_din  <= img_rows[r];
        end
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    task automatic read_blur(input row_addr_t a, output row_t d);
        @(posedge clk);
        blur_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = blur_dout;
    endtask

    task automatic read_kp(input kp_addr_t a, output kp_t d);
        @(posedge clk);
        kp_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = kp_dout;
    endtask

    task automatic run_core(input string name, input pixel_t thr, input bit extra_start);
        int base;
        int cycles;
        base = done_seen;
        @(posedge clk);
        threshold <= thr;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("%s: busy did not rise after start", name);
            abort_run();
        end
        if (extra_start) begin
            repeat (3) @(posedge clk);
            start <= 1'b1;  // should be ignored while busy
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 1000) begin
                $display("%s: timed out waiting for done", name);
                abort_run();
            end
        end
        if (busy !== 1'b0) begin
            $display("%s: busy still high when done pulsed", name);
            abort_run();
        end
        for (int i = 0; i < 20; i++) begin  // settle window to catch a stray second run
            @(negedge clk);
            if (busy !== 1'b0) begin
                $display("%s: core started again after done", name);
                abort_run();
            end
        end
        if (done_seen - base != 1) begin
            $display("%s: expected one done pulse but saw %0d", name, done_seen - base);
            abort_run();
        end
    endtask

    task automatic check_results(input string name);
        row_t got_row;
        kp_t  got_kp;
        for (int r = 0; r < img_h; r++) begin
            read_blur(row_addr_t'(r), got_row);
            check_row($sformatf("%s blur row %0d", name, r), blur_rows[r], got_row);
        end
        check_count($sformatf("%s kp_count", name), kp_count_t'(kp_ref.size()), kp_count);
        for (int i = 0; i < kp_ref.size(); i++) begin
            read_kp(kp_addr_t'(i), got_kp);
            check_kp($sformatf("%s keypoint %0d", name, i), kp_ref[i], got_kp);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("reset_state: busy or done not low after reset");
            abort_run();
        end
        check_count("reset_state kp_count", '0, kp_count);
    endtask

    task automatic test_flat_image();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                img_rows[r][c*pix_w +: pix_w] = pixel_t'(100);
            end
        end
        load_image();
        build_model(pixel_t'(10));
        run_core("flat_image", pixel_t'(10), 1'b0);
        check_results("flat_image");
    endtask

    task automatic test_random_image();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                img_rows[r][c*pix_w +: pix_w] = pixel_t'($random(seed));
            end
        end
        load_image();
        build_model(pixel_t'(20));
        run_core("random_image", pixel_t'(20), 1'b0);
        check_results("random_image");
    endtask

    task automatic test_high_threshold();
        build_model(pixel_t'(255));
        run_core("high_threshold", pixel_t'(255), 1'b0);
        check_count("high_threshold kp_count", '0, kp_count);
        check_results("high_threshold");
    endtask

    task automatic test_rerun_busy_start();
        build_model(pixel_t'(5));  // image left in memory from before
        run_core("rerun_busy_start", pixel_t'(5), 1'b1);
        check_results("rerun_busy_start");
    endtask

    initial begin
        seed      = 32'h48551f99;
        rst_n     <= 1'b0;
        start     <= 1'b0;
        threshold <= '0;
        img_we    <= 1'b0;
        img_addr  <= '0;
        img_din   <= '0;
        blur_addr <= '0;
        kp_addr   <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_flat_image();
        test_random_image();
        test_high_threshold();
        test_rerun_busy_start();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/feature_core_props.sv
`default_nettype none

module feature_core_props
    import feature_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      busy,
    input logic      done,
    input kp_count_t kp_count
);

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high for two cycles");

    // core is back in idle right after a run
    idle_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else $error("busy high in the cycle after done");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(kp_count) <= kp_depth)
        else $error("kp_count above keypoint memory depth");

endmodule

bind feature_core feature_core_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .busy     (busy),
    .done     (done),
    .kp_count (kp_count)
);

`default_nettype wire

// File: source/feature_core.sv
`default_nettype none

module feature_core
    import feature_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  pixel_t    threshold,
    input  logic      img_we,
    input  row_addr_t img_addr,
    input  row_t      img_din,
    input  row_addr_t blur_addr,
    output row_t      blur_dout,
    input  kp_addr_t  kp_addr,
    output kp_t       kp_dout,
    output kp_count_t kp_count,
    output logic      busy,
    output logic      done
);

    logic      blur_start;
    logic      blur_done;
    logic      detect_start;
    logic      detect_done;
    row_addr_t gb_img_addr;
    logic      gb_blur_we;
    row_addr_t gb_blur_addr;
    row_t      gb_blur_din;
    row_addr_t kd_rd_addr;
    logic      kd_kp_we;
    kp_addr_t  kd_kp_addr;
    kp_t       kd_kp_din;
    logic      img_mem_we;
    row_addr_t img_mem_addr;
    row_t      img_mem_din;
    row_t      img_mem_dout;
    logic      blur_mem_we;
    row_addr_t blur_mem_addr;
    row_t      blur_mem_din;
    logic      kp_mem_we;
    kp_addr_t  kp_mem_addr;
    kp_t       kp_mem_din;

    core_sequencer u_core_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .blur_done      (blur_done),
        .detect_done    (detect_done),
        .host_img_we    (img_we),
        .host_img_addr  (img_addr),
        .host_img_din   (img_din),
        .host_blur_addr (blur_addr),
        .host_kp_addr   (kp_addr),
        .gb_img_addr    (gb_img_addr),
        .gb_blur_we     (gb_blur_we),
        .gb_blur_addr   (gb_blur_addr),
        .gb_blur_din    (gb_blur_din),
        .kd_rd_addr     (kd_rd_addr),
        .kd_kp_we       (kd_kp_we),
        .kd_kp_addr     (kd_kp_addr),
        .kd_kp_din      (kd_kp_din),
        .img_mem_we     (img_mem_we),
        .img_mem_addr   (img_mem_addr),
        .img_mem_din    (img_mem_din),
        .blur_mem_we    (blur_mem_we),
        .blur_mem_addr  (blur_mem_addr),
        .blur_mem_din   (blur_mem_din),
        .kp_mem_we      (kp_mem_we),
        .kp_mem_addr    (kp_mem_addr),
        .kp_mem_din     (kp_mem_din),
        .blur_start     (blur_start),
        .detect_start   (detect_start),
        .busy           (busy),
        .done           (done)
    );

    gauss_blur u_gauss_blur (
        .clk          (clk),
        .rst_n        (rst_n),
        .blur_start   (blur_start),
        .img_rd_addr  (gb_img_addr),
        .img_dout     (img_mem_dout),
        .blur_we      (gb_blur_we),
        .blur_wr_addr (gb_blur_addr),
        .blur_din     (gb_blur_din),
        .blur_done    (blur_done)
    );

    keypoint_detect u_keypoint_detect (
        .clk          (clk),
        .rst_n        (rst_n),
        .detect_start (detect_start),
        .threshold    (threshold),
        .rd_addr      (kd_rd_addr),
        .img_dout     (img_mem_dout),
        .blur_dout    (blur_dout),
        .kp_we        (kd_kp_we),
        .kp_wr_addr   (kd_kp_addr),
        .kp_din       (kd_kp_din),
        .kp_count     (kp_count),
        .detect_done  (detect_done)
    );

    row_mem #(.data_t(row_t), .depth(img_h)) img_mem (
        .clk  (clk),
        .we   (img_mem_we),
        .addr (img_mem_addr),
        .din  (img_mem_din),
        .dout (img_mem_dout)
    );

    // readback port doubles as the detect stage's blurred row
    row_mem #(.data_t(row_t), .depth(img_h)) blur_mem (
        .clk  (clk),
        .we   (blur_mem_we),
        .addr (blur_mem_addr),
        .din  (blur_mem_din),
        .dout (blur_dout)
    );

    row_mem #(.data_t(kp_t), .depth(kp_depth)) kp_mem (
        .clk  (clk),
        .we   (kp_mem_we),
        .addr (kp_mem_addr),
        .din  (kp_mem_din),
        .dout (kp_dout)
    );

endmodule

`default_nettype wire

// File: source/core_sequencer.sv
`default_nettype none

module core_sequencer
    import feature_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      blur_done,
    input  logic      detect_done,
    input  logic      host_img_we,
    input  row_addr_t host_img_addr,
    input  row_t      host_img_din,
    input  row_addr_t host_blur_addr,
    input  kp_addr_t  host_kp_addr,
    input  row_addr_t gb_img_addr,
    input  logic      gb_blur_we,
    input  row_addr_t gb_blur_addr,
    input  row_t      gb_blur_din,
    input  row_addr_t kd_rd_addr,
    input  logic      kd_kp_we,
    input  kp_addr_t  kd_kp_addr,
    input  kp_t       kd_kp_din,
    output logic      img_mem_we,
    output row_addr_t img_mem_addr,
    output row_t      img_mem_din,
    output logic      blur_mem_we,
    output row_addr_t blur_mem_addr,
    output row_t      blur_mem_din,
    output logic      kp_mem_we,
    output kp_addr_t  kp_mem_addr,
    output kp_t       kp_mem_din,
    output logic      blur_start,
    output logic      detect_start,
    output logic      busy,
    output logic      done
);

    phase_t phase;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= ph_idle;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            done         <= 1'b0;
        end else begin
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            done         <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (start) begin
                        phase      <= ph_blur;
                        blur_start <= 1'b1;
                    end
                end
                ph_blur: begin
                    if (blur_done) begin
                        phase        <= ph_detect;
                        detect_start <= 1'b1;
                    end
                end
                ph_detect: begin
                    if (detect_done) begin
                        phase <= ph_idle;
                        done  <= 1'b1;  // same edge as busy falling
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    assign busy = (phase != ph_idle);

    // only the host writes the image, only the stages write the others
    assign img_mem_we    = (phase == ph_idle) && host_img_we;
    assign img_mem_addr  = (phase == ph_blur)   ? gb_img_addr :
                           (phase == ph_detect) ? kd_rd_addr  : host_img_addr;
    assign img_mem_din   = host_img_din;

    assign blur_mem_we   = (phase == ph_blur) && gb_blur_we;
    assign blur_mem_addr = (phase == ph_blur)   ? gb_blur_addr :
                           (phase == ph_detect) ? kd_rd_addr   : host_blur_addr;
    assign blur_mem_din  = gb_blur_din;

    assign kp_mem_we     = (phase != ph_idle) && kd_kp_we;
    assign kp_mem_addr   = (phase == ph_idle) ? host_kp_addr : kd_kp_addr;
    assign kp_mem_din    = kd_kp_din;

endmodule

`default_nettype wire

// File: source/keypoint_detect.sv
`default_nettype none

module keypoint_detect
    import feature_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      detect_start,
    input  pixel_t    threshold,
    output row_addr_t rd_addr,
    input  row_t      img_dout,
    input  row_t      blur_dout,
    output logic      kp_we,
    output kp_addr_t  kp_wr_addr,
    output kp_t       kp_din,
    output kp_count_t kp_count,
    output logic      detect_done
);

    typedef enum logic [1:0] {
        ds_idle,
        ds_read,
        ds_latch,
        ds_scan
    } det_state_t;

    det_state_t state;
    row_addr_t  row;
    col_t       col;
    row_t       img_q;
    row_t       blur_q;
    pixel_t     img_px;
    pixel_t     blur_px;
    pixel_t     diff;
    logic       hit;

    assign rd_addr = row;  // same row of both memories

    assign img_px  = img_q[col*pix_w +: pix_w];
    assign blur_px = blur_q[col*pix_w +: pix_w];
    assign diff    = (img_px > blur_px) ? img_px - blur_px : blur_px - img_px;
    assign hit     = diff > threshold;

    assign kp_we      = (state == ds_scan) && hit;
    assign kp_wr_addr = kp_addr_t'(kp_count);  // list grows in raster order
    assign kp_din     = '{row: row, col: col};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ds_idle;
            row         <= '0;
            col         <= '0;
            kp_count    <= '0;
            detect_done <= 1'b0;
        end else begin
            detect_done <= 1'b0;
            case (state)
                ds_idle: begin
                    if (detect_start) begin
                        row      <= '0;
                        kp_count <= '0;
                        state    <= ds_read;
                    end
                end
                ds_read: begin
                    state <= ds_latch;  // address presented, data next cycle
                end
                ds_latch: begin
                    col   <= '0;
                    state <= ds_scan;
                end
                ds_scan: begin
                    if (hit) begin
                        kp_count <= kp_count + kp_count_t'(1);
                    end
                    col <= col + col_t'(1);
                    if (col == col_t'(img_w - 1)) begin
                        if (row == row_addr_t'(img_h - 1)) begin
                            detect_done <= 1'b1;
                            state       <= ds_idle;
                        end else begin
                            row   <= row + row_addr_t'(1);
                            state <= ds_read;
                        end
                    end
                end
                default: state <= ds_idle;
            endcase
        end
    end

    // row payload only
    always_ff @(posedge clk) begin
        if (state == ds_latch) begin
            img_q  <= img_dout;
            blur_q <= blur_dout;
        end
    end

endmodule

`default_nettype wire

// File: source/gauss_blur.sv
`default_nettype none

module gauss_blur
    import feature_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      blur_start,
    output row_addr_t img_rd_addr,
    input  row_t      img_dout,
    output logic      blur_we,
    output row_addr_t blur_wr_addr,
    output row_t      blur_din,
    output logic      blur_done
);

    localparam row_addr_t last_row = row_addr_t'(img_h - 1);

    row_addr_t        rd_row;
    logic             rd_on;
    logic             rd_vld;     // img_dout carries row vld_row
    row_addr_t        vld_row;
    logic             fill_zero;  // extra shift for the row below the image
    logic             win_vld;
    row_addr_t        wr_row;
    logic             shift;
    row_t             win_din;
    row_t             row_above;
    row_t             row_mid;
    row_t             row_below;
    logic [pix_w+1:0] vsum [img_w+2];
    logic [pix_w+3:0] hsum [img_w];
    row_t             blur_row;

    assign img_rd_addr = rd_row;
    assign shift       = rd_vld | fill_zero;
    assign win_din     = fill_zero ? '0 : img_dout;

    line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (blur_start),
        .shift     (shift),
        .din       (win_din),
        .row_above (row_above),
        .row_mid   (row_mid),
        .row_below (row_below)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_row    <= '0;
            rd_on     <= 1'b0;
            rd_vld    <= 1'b0;
            vld_row   <= '0;
            fill_zero <= 1'b0;
            win_vld   <= 1'b0;
            wr_row    <= '0;
            blur_done <= 1'b0;
        end else begin
            rd_vld    <= rd_on;
            vld_row   <= rd_row;
            fill_zero <= rd_vld && (vld_row == last_row);
            // centred row is complete once the row below it has arrived
            win_vld   <= (rd_vld && (vld_row != '0)) || fill_zero;
            blur_done <= win_vld && (wr_row == last_row);
            if (blur_start) begin
                rd_row <= '0;
                rd_on  <= 1'b1;
                wr_row <= '0;
            end else begin
                if (rd_on) begin
                    rd_row <= rd_row + row_addr_t'(1);
                    if (rd_row == last_row) begin
                        rd_on <= 1'b0;
                    end
                end
                if (win_vld) begin
                    wr_row <= wr_row + row_addr_t'(1);
                end
            end
        end
    end

    // vertical 1-2-1, then horizontal 1-2-1 over zero padded columns
    always_comb begin
        vsum[0]       = '0;
        vsum[img_w+1] = '0;
        for (int c = 0; c < img_w; c++) begin
            vsum[c+1] = {2'b00, row_above[c*pix_w +: pix_w]}
                      + {1'b0, row_mid[c*pix_w +: pix_w], 1'b0}
                      + {2'b00, row_below[c*pix_w +: pix_w]};
        end
        for (int c = 0; c < img_w; c++) begin
            hsum[c] = {2'b00, vsum[c]} + {1'b0, vsum[c+1], 1'b0} + {2'b00, vsum[c+2]};
            blur_row[c*pix_w +: pix_w] = hsum[c][gauss_shift +: pix_w];  // truncating divide
        end
    end

    assign blur_we      = win_vld;
    assign blur_wr_addr = wr_row;
    assign blur_din     = blur_row;

endmodule

`default_nettype wire

// File: source/line_buffer.sv
`default_nettype none

module line_buffer
    import feature_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    input  logic shift,
    input  row_t din,
    output row_t row_above,
    output row_t row_mid,
    output row_t row_below
);

    // window moves down one row per shift, new row enters at the bottom
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            row_above <= '0;  // zero row above the image
            row_mid   <= '0;
            row_below <= '0;
        end else if (shift) begin
            row_above <= row_mid;
            row_mid   <= row_below;
            row_below <= din;
        end
    end

endmodule

`default_nettype wire

// File: source/row_mem.sv
`default_nettype none

module row_mem #(
    parameter type data_t = logic [7:0],
    parameter int  depth  = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr,
    input  data_t                    din,
    output data_t                    dout
);

    data_t mem [depth];

    // read returns old contents on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/feature_pkg.sv
`default_nettype none

package feature_pkg;

    // image geometry
    localparam int img_w       = 16;
    localparam int img_h       = 16;
    localparam int pix_w       = 8;

    localparam int kp_depth    = 256;  // one entry per pixel at most
    localparam int gauss_shift = 4;    // 1-2-1 x 1-2-1 sums to 16

    typedef logic [pix_w-1:0]          pixel_t;
    typedef logic [img_w*pix_w-1:0]    row_t;    // pixel 0 in the low byte
    typedef logic [$clog2(img_h)-1:0]  row_addr_t;
    typedef logic [$clog2(img_w)-1:0]  col_t;

    typedef struct packed {
        row_addr_t row;
        col_t      col;
    } kp_t;

    typedef logic [$clog2(kp_depth)-1:0] kp_addr_t;
    typedef logic [$clog2(kp_depth):0]   kp_count_t;  // one extra bit to hold a full list

    typedef enum logic [1:0] {
        ph_idle,
        ph_blur,
        ph_detect
    } phase_t;

endpackage

`default_nettype wire
